// File: rtl/loader_map_pkg.sv
// Widths and fixed constants of the ROM loader memory map
// Page codes are 9 bits: bit 8 selects the upper expansion space
// Memory addresses are byte addresses inside one 8 MB bank
`default_nettype none

package loader_map_pkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;       // Host download address
	typedef logic [22:0] mem_addr_t;      // Bit 22 marks upper expansion space
	typedef logic [8:0]  page_t;          // 16 KB page base
	typedef logic [7:0]  map_index_t;     // One entry per upper page
	typedef logic [15:0] file_ext_t;      // Last two extension characters

	////////////////////////////////////////////////////////////
	// Memory reference pacing
	////////////////////////////////////////////////////////////

	localparam int CE_REF_DIV = 16;       // Clocks per reference slot
	localparam int CE_REF_W = $clog2(CE_REF_DIV);

	typedef logic [CE_REF_W-1:0] ref_cnt_t;

	localparam ref_cnt_t CE_REF_LAST = ref_cnt_t'(CE_REF_DIV - 1);

	////////////////////////////////////////////////////////////
	// Page codes
	////////////////////////////////////////////////////////////

	// System slot modulo 4 picks the page, slot bit 2 picks the bank
	localparam page_t SYS_SLOT_PAGE [4] = '{9'h000, 9'h100, 9'h107, 9'h1FF};
	localparam int    SYS_SLOTS = 8;

	localparam page_t PAGE_BAD_EXT    = 9'h1EE;  // Unused page for odd extensions
	localparam page_t PAGE_COMBO_NEXT = 9'h1FF;

	// Pages 0, 7 and 255 are always present
	localparam logic [255:0] MAP_DEFAULT_PAGES = (256'd1 << 255) | (256'd1 << 7) | 256'd1;

endpackage

`default_nettype wire

// File: rtl/loader_bus_pkg.sv
// Grouped buses and the loader state type
// Field order fixes the packed layout: address on top, data byte at the bottom
`default_nettype none

package loader_bus_pkg;

	////////////////////////////////////////////////////////////
	// Download side
	////////////////////////////////////////////////////////////

	// One byte from the host, 33 bits
	typedef struct packed {
		loader_map_pkg::dl_addr_t addr;
		loader_map_pkg::byte_t    data;
	} dl_beat_t;

	////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////

	// One write command for external memory, 32 bits
	typedef struct packed {
		loader_map_pkg::mem_addr_t addr;
		logic                      bank;    // 0 for lower system slots and model 0
		loader_map_pkg::byte_t     data;
	} mem_wr_t;

	////////////////////////////////////////////////////////////
	// Write sequencer
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,     // Ready for a beat
		PENDING,  // Waiting for the next reference slot
		WRITING   // Write enable held for one full slot
	} loader_state_t;

endpackage

`default_nettype wire

// File: rtl/ce_ref_timer.sv
// Free-running reference enable, one clock high every CE_REF_DIV clocks
// Phase is fixed by reset only
`default_nettype none

module ce_ref_timer (
	input  wire  clk_sys,
	input  wire  reset,
	output logic ce_ref
);
	import loader_map_pkg::*;

	ref_cnt_t div_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (div_cnt == CE_REF_LAST) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign ce_ref = (div_cnt == CE_REF_LAST);  // High in the cycle before wrap

endmodule

`default_nettype wire

// File: rtl/boot_fsm.sv
// Admits one download beat at a time and paces its memory write
// The host must not strobe while dl_wait is high
// dl_wait spans 17 to 32 clocks, mem_we exactly one reference period
`default_nettype none

module boot_fsm (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  dl_active,
	input  wire  dl_wr,
	input  wire  beat_ok,
	input  wire  ce_ref,
	output logic dl_wait,
	output logic mem_we,
	output logic commit
);
	import loader_bus_pkg::*;

	loader_state_t state;

	////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					// Dropped system beats never leave IDLE
					if (dl_wr && dl_active && beat_ok) begin
						state <= PENDING;
					end
				end
				PENDING: begin
					if (ce_ref) begin
						state <= WRITING;   // Align to the slot boundary
					end
				end
				WRITING: begin
					if (ce_ref) begin
						state <= IDLE;      // Write retired
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	assign dl_wait = (state != IDLE);
	assign mem_we  = (state == WRITING);

	// Last cycle of WRITING, data blocks update on this edge
	assign commit = (state == WRITING) && ce_ref;

endmodule

`default_nettype wire

// File: rtl/rom_page_decoder.sv
// Maps a download beat to memory address, bank and data
// dl_ext must be stable before dl_active rises; the page base loads on that edge
// A beat on the very edge where dl_active rises still sees the old page base
`default_nettype none

module rom_page_decoder (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        dl_active,
	input  wire                        dl_index_nz,  // Expansion download
	input  loader_map_pkg::file_ext_t  dl_ext,
	input  loader_bus_pkg::dl_beat_t   beat,
	input  wire                        take,
	input  wire                        commit,
	input  wire                        model,
	output logic                       beat_ok,
	output loader_bus_pkg::mem_wr_t    mem_cmd
);
	import loader_map_pkg::*;

	page_t      page;
	logic       combo;           // "Z0" pair of pages still in its first page
	logic       dl_active_d;
	logic [10:0] sys_slot;

	// Uppercase hex digit replaces the nibble, anything else keeps it
	function automatic logic [3:0] hex_nibble(input byte_t ch, input logic [3:0] dflt);
		logic [3:0] nib;
		nib = dflt;
		if (ch >= "0" && ch <= "9") begin
			nib = ch[3:0];
		end else if (ch >= "A" && ch <= "F") begin
			nib = ch[3:0] + 4'd9;
		end
		return nib;
	endfunction

	assign sys_slot = beat.addr[24:14];  // 16 KB slot number

	// System slots past the last fixed page are ignored
	assign beat_ok = dl_index_nz || (sys_slot < SYS_SLOTS);

	////////////////////////////////////////////////////////////
	// Page base and combo tracking
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page        <= '0;
			combo       <= 1'b0;
			dl_active_d <= 1'b0;
		end else begin
			dl_active_d <= dl_active;

			// End of the first combo page moves on to the fixed second page
			if (commit && combo && (&mem_cmd.addr[13:0])) begin
				combo <= 1'b0;
				page  <= PAGE_COMBO_NEXT;
			end

			if (!dl_active_d && dl_active && dl_index_nz) begin
				combo <= 1'b0;
				page  <= {PAGE_BAD_EXT[8],
				          hex_nibble(dl_ext[15:8], PAGE_BAD_EXT[7:4]),
				          hex_nibble(dl_ext[7:0], PAGE_BAD_EXT[3:0])};
				if (dl_ext == "ZZ") begin
					page <= '0;
				end
				if (dl_ext == "Z0") begin
					page  <= '0;
					combo <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Write command capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (take) begin
			mem_cmd.data       <= beat.data;
			mem_cmd.addr[13:0] <= beat.addr[13:0];
			if (dl_index_nz) begin
				mem_cmd.addr[22:14] <= {page[8], page[7:0] + beat.addr[21:14]};  // Wraps at 256
				mem_cmd.bank        <= model;
			end else begin
				mem_cmd.addr[22:14] <= SYS_SLOT_PAGE[sys_slot[1:0]];
				mem_cmd.bank        <= sys_slot[2];      // Upper four slots
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/rom_map_table.sv
// Tracks which upper pages hold a ROM image and answers the mask query
// Model is latched on reset; a changed model drops back to the default pages
// Power-on state is the default map with model 0
`default_nettype none

module rom_map_table (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        model_sel,
	input  wire                        commit,
	input  loader_bus_pkg::mem_wr_t    mem_cmd,
	input  loader_map_pkg::mem_addr_t  query_addr,
	output logic                       model,
	output loader_map_pkg::byte_t      rom_mask
);
	import loader_map_pkg::*;

	logic [255:0] page_map = MAP_DEFAULT_PAGES;
	logic         model_q = 1'b0;
	map_index_t   wr_idx;
	map_index_t   q_idx;

	assign wr_idx = mem_cmd.addr[21:14];
	assign q_idx  = query_addr[21:14];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model_sel;
			if (model_q != model_sel) begin
				page_map <= MAP_DEFAULT_PAGES;  // New machine, forget loaded pages
			end
		end else if (commit && mem_cmd.addr[22]) begin
			page_map[wr_idx] <= 1'b1;
		end
	end

	assign model = model_q;

	// Unloaded upper pages read as all ones
	assign rom_mask = (query_addr[22] && !page_map[q_idx]) ? 8'hFF : 8'h00;

endmodule

`default_nettype wire

// File: rtl/rom_loader_top.sv
// Expansion ROM loader: host byte stream in, paced memory writes out
// Host strobes dl_wr only while dl_wait is low
// rom_mask is combinational from query_addr
`default_nettype none

module rom_loader_top (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        dl_active,
	input  wire                        dl_wr,
	input  loader_map_pkg::dl_addr_t   dl_addr,
	input  loader_map_pkg::byte_t      dl_data,
	input  wire                        dl_index_nz,
	input  loader_map_pkg::file_ext_t  dl_ext,
	input  wire                        model_sel,
	input  loader_map_pkg::mem_addr_t  query_addr,
	output logic                       dl_wait,
	output logic                       mem_we,
	output loader_bus_pkg::mem_wr_t    mem_cmd,
	output loader_map_pkg::byte_t      rom_mask
);
	import loader_bus_pkg::*;

	dl_beat_t beat;
	logic     ce_ref;
	logic     beat_ok;
	logic     take;
	logic     commit;
	logic     model;

	assign beat = {dl_addr, dl_data};
	assign take = dl_active && dl_wr && beat_ok && !dl_wait;  // Same as the FSM leaving IDLE

	////////////////////////////////////////////////////////////
	// Pacing and sequencing
	////////////////////////////////////////////////////////////

	ce_ref_timer ce_ref_timer_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_ref  (ce_ref)
	);

	boot_fsm boot_fsm_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.beat_ok   (beat_ok),
		.ce_ref    (ce_ref),
		.dl_wait   (dl_wait),
		.mem_we    (mem_we),
		.commit    (commit)
	);

	////////////////////////////////////////////////////////////
	// Address decode and page map
	////////////////////////////////////////////////////////////

	rom_page_decoder rom_page_decoder_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_index_nz (dl_index_nz),
		.dl_ext      (dl_ext),
		.beat        (beat),
		.take        (take),
		.commit      (commit),
		.model       (model),
		.beat_ok     (beat_ok),
		.mem_cmd     (mem_cmd)
	);

	rom_map_table rom_map_table_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.model_sel  (model_sel),
		.commit     (commit),
		.mem_cmd    (mem_cmd),
		.query_addr (query_addr),
		.model      (model),
		.rom_mask   (rom_mask)
	);

endmodule

`default_nettype wire

// File: test/tb_rom_loader.sv
// Testbench for the ROM loader covering system slots, dropped beats, expansion pages,
// ROM mask, model change and the combo page pair
// The host side keeps the next beat back until dl_wait falls
`default_nettype none

module tb_rom_loader;
	timeunit 1ns;
	timeprecision 1ps;

	import loader_map_pkg::*;
	import loader_bus_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int TOTAL_BEATS = 25;
	localparam int CYCLE_LIMIT = 40 * TOTAL_BEATS + 2000;

	logic      clk_sys = 1'b0;
	logic      reset = 1'b1;
	logic      dl_active = 1'b0;
	logic      dl_wr = 1'b0;
	dl_addr_t  dl_addr = '0;
	byte_t     dl_data = '0;
	logic      dl_index_nz = 1'b0;
	file_ext_t dl_ext = "00";
	logic      model_sel = 1'b0;
	mem_addr_t query_addr = '0;
	logic      dl_wait;
	logic      mem_we;
	mem_wr_t   mem_cmd;
	byte_t     rom_mask;

	mem_wr_t expect_q [$];          // One entry per accepted beat
	logic    exp_map [256];         // Expected page map
	page_t   cur_base = '0;
	logic    cur_combo = 1'b0;
	logic    cur_model = 1'b0;
	string   test_name = "startup";
	int      errors = 0;
	int      test_errors = 0;
	int      tests_run = 0;
	int      tests_failed = 0;
	int      cycles = 0;

	rom_loader_top rom_loader_top_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles in test %s, the run did not complete",
				cycles, test_name);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Page base from the two extension characters
	function automatic page_t ext_page(input file_ext_t ext);
		page_t p;
		byte_t hi;
		byte_t lo;
		p = 9'h1EE;
		hi = ext[15:8];
		lo = ext[7:0];
		if (hi >= "0" && hi <= "9") p[7:4] = 4'(hi - 8'h30);
		else if (hi >= "A" && hi <= "F") p[7:4] = 4'(hi - 8'h37);
		if (lo >= "0" && lo <= "9") p[3:0] = 4'(lo - 8'h30);
		else if (lo >= "A" && lo <= "F") p[3:0] = 4'(lo - 8'h37);
		if (ext == "ZZ" || ext == "Z0") p = 9'h000;
		return p;
	endfunction

	function automatic mem_wr_t expected_write(input dl_addr_t a, input byte_t d, input logic nz,
			input page_t base, input logic mdl, output logic ok);
		mem_wr_t w;
		logic [10:0] slot;
		page_t pg;
		slot = a[24:14];
		w.data = d;
		w.addr[13:0] = a[13:0];
		if (nz) begin
			ok = 1'b1;
			w.addr[22] = base[8];
			w.addr[21:14] = base[7:0] + a[21:14];    // 8-bit wrap
			w.bank = mdl;
		end else begin
			ok = (slot < 11'd8);
			case (slot[1:0])
				2'd0: pg = 9'h000;
				2'd1: pg = 9'h100;
				2'd2: pg = 9'h107;
				default: pg = 9'h1FF;
			endcase
			w.addr[22:14] = pg;
			w.bank = slot[2];
		end
		return w;
	endfunction

	function automatic byte_t expected_mask(input mem_addr_t qa);
		return (qa[22] && !exp_map[qa[21:14]]) ? 8'hFF : 8'h00;
	endfunction

	function automatic mem_addr_t upper_addr(input map_index_t idx);
		return {1'b1, idx, 14'h0123};
	endfunction

	function automatic void load_default_map();
		foreach (exp_map[i]) exp_map[i] = (i == 0 || i == 7 || i == 255);
	endfunction

	////////////////////////////////////////////////////////////
	// Write checker
	////////////////////////////////////////////////////////////

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	mem_wr_t cur_exp = '0;
	mem_wr_t first_cmd = '0;
	logic    we_prev = 1'b0;
	int      we_len = 0;

	always @(negedge clk_sys) begin
		if (mem_we) begin
			if (!we_prev) begin
				we_len = 0;
				first_cmd = mem_cmd;
				assert (expect_q.size() > 0) else
					report_error($sformatf("Test %s: memory write with no beat pending",
						test_name));
				if (expect_q.size() > 0) cur_exp = expect_q.pop_front();
				assert (mem_cmd === cur_exp) else
					report_error($sformatf("MISMATCH %s mem_cmd expected %h actual %h",
						test_name, cur_exp, mem_cmd));
			end
			assert (mem_cmd === first_cmd) else
				report_error($sformatf("Test %s: mem_cmd changed while mem_we was high",
					test_name));
			we_len++;
		end else if (we_prev) begin
			assert (we_len == 16) else
				report_error($sformatf("MISMATCH %s mem_we length expected 16 actual %0d",
					test_name, we_len));
		end
		we_prev = mem_we;
	end

	////////////////////////////////////////////////////////////
	// Host side tasks
	////////////////////////////////////////////////////////////

	task automatic apply_reset(input logic m);
		@(negedge clk_sys);
		model_sel = m;
		reset = 1'b1;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		if (m != cur_model) load_default_map();
		cur_model = m;
	endtask

	task automatic start_download(input logic nz, input file_ext_t ext);
		@(negedge clk_sys);
		dl_index_nz = nz;
		dl_ext = ext;
		@(negedge clk_sys);
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);   // Page base loads on the rising edge
		cur_base = ext_page(ext);
		cur_combo = (ext == "Z0");
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		dl_active = 1'b0;
	endtask

	task automatic send_beat(input dl_addr_t a, input byte_t d);
		mem_wr_t exp_cmd;
		logic ok;
		logic busy;
		int waited;
		exp_cmd = expected_write(a, d, dl_index_nz, cur_base, cur_model, ok);
		@(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		if (ok) expect_q.push_back(exp_cmd);
		@(negedge clk_sys);
		dl_wr = 1'b0;
		waited = 0;
		if (ok) begin
			assert (dl_wait) else
				report_error($sformatf("Test %s: dl_wait did not rise for beat at %h",
					test_name, a));
			while (dl_wait && waited < 40) begin
				@(negedge clk_sys);
				waited++;
			end
			assert (waited >= 17 && waited <= 32) else
				report_error($sformatf("Test %s: dl_wait lasted %0d cycles, not 17 to 32",
					test_name, waited));
			if (exp_cmd.addr[22]) exp_map[exp_cmd.addr[21:14]] = 1'b1;
			if (dl_index_nz && cur_combo && a[13:0] == 14'h3FFF) begin
				cur_combo = 1'b0;
				cur_base = 9'h1FF;
			end
			@(negedge clk_sys);
		end else begin
			busy = 1'b0;
			repeat (40) begin
				@(negedge clk_sys);
				busy = busy | dl_wait | mem_we;
			end
			assert (!busy) else
				report_error($sformatf("Test %s: dropped beat at %h raised dl_wait or mem_we",
					test_name, a));
		end
	endtask

	task automatic check_mask(input mem_addr_t qa);
		byte_t exp_m;
		@(negedge clk_sys);
		query_addr = qa;
		exp_m = expected_mask(qa);
		#(CLK_PERIOD / 4);
		assert (rom_mask === exp_m) else
			report_error($sformatf("MISMATCH %s rom_mask at %h expected %h actual %h",
				test_name, qa, exp_m, rom_mask));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("Test %s: %s (%0d errors)", test_name,
			(test_errors == 0) ? "ok" : "failed", test_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h3dd860ad));
		load_default_map();
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;

		begin_test("system_slots");
		start_download(1'b0, "00");
		for (int s = 0; s < 8; s++) send_beat({11'(s), 14'($urandom)}, 8'($urandom));
		finish_test();

		begin_test("dropped_beats");
		send_beat({11'h008, 14'($urandom)}, 8'($urandom));
		send_beat({11'h7FF, 14'($urandom)}, 8'($urandom));
		end_download();
		finish_test();

		begin_test("expansion_pages");
		start_download(1'b1, "3C");
		for (int k = 0; k < 3; k++) send_beat({11'(k), 14'($urandom)}, 8'($urandom));
		end_download();
		start_download(1'b1, "a1");
		for (int k = 0; k < 3; k++) send_beat({11'(k), 14'($urandom)}, 8'($urandom));
		end_download();
		start_download(1'b1, "ZZ");
		for (int k = 0; k < 3; k++) send_beat({11'(k), 14'($urandom)}, 8'($urandom));
		end_download();
		finish_test();

		begin_test("rom_mask");
		check_mask(upper_addr(8'h3C));
		check_mask(upper_addr(8'hE1));
		check_mask(upper_addr(8'h00));
		check_mask(upper_addr(8'h07));
		check_mask(upper_addr(8'hFF));
		check_mask(23'h200123);         // Bit 22 clear on an unloaded index
		check_mask(upper_addr(8'h80));  // Never written
		finish_test();

		begin_test("model_change");
		apply_reset(1'b1);
		check_mask(upper_addr(8'h3C));
		check_mask(upper_addr(8'h3D));
		start_download(1'b1, "3C");
		send_beat({11'h000, 14'($urandom)}, 8'($urandom));
		end_download();
		apply_reset(1'b1);                // Same model keeps the map
		check_mask(upper_addr(8'h3C));
		check_mask(upper_addr(8'h3D));
		start_download(1'b1, "3C");
		send_beat({11'h002, 14'($urandom)}, 8'($urandom));
		end_download();
		finish_test();

		begin_test("combo");
		start_download(1'b1, "Z0");
		send_beat(25'h0003FFF, 8'($urandom));
		send_beat(25'h0004000, 8'($urandom));
		send_beat(25'h0000010, 8'($urandom));
		send_beat(25'h0008000, 8'($urandom));
		end_download();
		check_mask(upper_addr(8'h01));
		check_mask(upper_addr(8'h02));
		finish_test();

		assert (expect_q.size() == 0) else
			report_error($sformatf("%0d expected writes never happened", expect_q.size()));
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/loader_map_pkg.sv
rtl/loader_bus_pkg.sv
rtl/ce_ref_timer.sv
rtl/boot_fsm.sv
rtl/rom_page_decoder.sv
rtl/rom_map_table.sv
rtl/rom_loader_top.sv
test/tb_rom_loader.sv

// File: Bender.yml
package:
  name: rom_loader

sources:
  - rtl/loader_map_pkg.sv
  - rtl/loader_bus_pkg.sv
  - rtl/ce_ref_timer.sv
  - rtl/boot_fsm.sv
  - rtl/rom_page_decoder.sv
  - rtl/rom_map_table.sv
  - rtl/rom_loader_top.sv
  - target: test
    files:
      - test/tb_rom_loader.sv
